//--- Makefile
# Verilator build and run for the command parser testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_cmd_parser
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors
SOURCES   := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/cmd_defines.svh
`ifndef CMD_DEFINES_SVH
`define CMD_DEFINES_SVH

// ========================================
// field widths
// ========================================
`define CMD_BYTE_W 8   // rx byte and number buffer
`define CMD_DIM_W  3   // matrix dimension m, n
`define CMD_ID_W   4   // matrix id and gen count
`define CMD_CNT_W  5   // element counter

// ========================================
// ascii codes
// ========================================
`define CMD_ASCII_0     8'd48
`define CMD_ASCII_9     8'd57
`define CMD_ASCII_SPACE 8'd32
`define CMD_ASCII_CR    8'd13
`define CMD_ASCII_LF    8'd10

`endif

//--- source/cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fsm (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  cmd_pkg::mode_t        mode_sel,
    input  wire logic             start_input,
    input  wire logic             start_gen,
    input  wire logic             in_operand_select,
    input  cmd_pkg::token_t       token,
    input  wire logic             elem_done,
    output cmd_pkg::load_t        load,
    output logic                  acc_clear,
    output logic                  cnt_clear,
    output logic                  count_en
);

    cmd_pkg::parser_state_t state;
    cmd_pkg::parser_state_t next_state;

    // ========================================
    // state register and next state
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= cmd_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            cmd_pkg::IDLE: begin
                if (in_operand_select)  // select wins over the starts
                    next_state = cmd_pkg::WAIT_ID_A;
                else if (start_input || start_gen)
                    next_state = cmd_pkg::WAIT_M;
            end
            cmd_pkg::WAIT_M:
                if (token.valid) next_state = cmd_pkg::WAIT_N;
            cmd_pkg::WAIT_N: begin
                if (token.valid) begin
                    if (mode_sel == cmd_pkg::MODE_INPUT || mode_sel == cmd_pkg::MODE_GEN)
                        next_state = cmd_pkg::WAIT_DATA;
                    else
                        next_state = cmd_pkg::DONE;  // no payload for other modes
                end
            end
            cmd_pkg::WAIT_DATA: begin
                case (mode_sel)
                    cmd_pkg::MODE_INPUT: if (elem_done) next_state = cmd_pkg::DONE;
                    cmd_pkg::MODE_GEN:   if (token.valid) next_state = cmd_pkg::DONE;
                    default:             next_state = cmd_pkg::DONE;
                endcase
            end
            cmd_pkg::WAIT_ID_A:
                if (token.valid) next_state = cmd_pkg::WAIT_ID_B;
            cmd_pkg::WAIT_ID_B:
                if (token.valid) next_state = cmd_pkg::DONE;
            cmd_pkg::DONE:
                next_state = cmd_pkg::IDLE;
            default:
                next_state = cmd_pkg::IDLE;
        endcase
    end

    // ========================================
    // field selection for the current token
    // ========================================
    always_comb begin
        load       = '0;
        load.dim_m = token.valid && (state == cmd_pkg::WAIT_M);
        load.dim_n = token.valid && (state == cmd_pkg::WAIT_N);
        load.elem  = token.valid && (state == cmd_pkg::WAIT_DATA) &&
                     (mode_sel == cmd_pkg::MODE_INPUT) && !elem_done;  // extra elements dropped
        load.count = token.valid && (state == cmd_pkg::WAIT_DATA) &&
                     (mode_sel == cmd_pkg::MODE_GEN);
        load.id_a  = token.valid && (state == cmd_pkg::WAIT_ID_A);
        load.id_b  = token.valid && (state == cmd_pkg::WAIT_ID_B);
        load.done  = (state == cmd_pkg::DONE);
    end

    assign acc_clear = (state == cmd_pkg::IDLE);
    assign cnt_clear = (state == cmd_pkg::IDLE);
    assign count_en  = load.elem || (load.count && !elem_done);

    a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
        state inside {cmd_pkg::IDLE, cmd_pkg::WAIT_M, cmd_pkg::WAIT_N, cmd_pkg::WAIT_DATA,
                      cmd_pkg::WAIT_ID_A, cmd_pkg::WAIT_ID_B, cmd_pkg::DONE});

endmodule

`default_nettype wire

//--- source/cmd_pkg.sv
`default_nettype none

`include "cmd_defines.svh"

package cmd_pkg;

    // command grammar states
    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        WAIT_M    = 4'd1,
        WAIT_N    = 4'd2,
        WAIT_DATA = 4'd3,
        WAIT_ID_A = 4'd4,
        WAIT_ID_B = 4'd5,
        DONE      = 4'd6
    } parser_state_t;

    // same encoding as the mode_sel pins
    typedef enum logic [1:0] {
        MODE_NONE  = 2'd0,
        MODE_INPUT = 2'd1,
        MODE_GEN   = 2'd2,
        MODE_OTHER = 2'd3
    } mode_t;

    // one finished number, valid on its delimiter byte only
    typedef struct packed {
        logic                   valid;
        logic [`CMD_BYTE_W-1:0] value;
    } token_t;

    // target field of the current token
    typedef struct packed {
        logic dim_m;
        logic dim_n;
        logic elem;
        logic count;
        logic id_a;
        logic id_b;
        logic done;
    } load_t;

endpackage

`default_nettype wire

//--- source/decimal_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

module decimal_accumulator (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`CMD_BYTE_W-1:0] rx_data,
    input  wire logic                   rx_valid,
    input  wire logic                   clear,
    output cmd_pkg::token_t             token
);

    logic [`CMD_BYTE_W-1:0] num_buffer;
    logic                   num_building;  // at least one digit seen
    logic [`CMD_BYTE_W-1:0] digit;
    logic                   is_digit;
    logic                   is_delim;

    // ========================================
    // byte classification
    // ========================================
    assign is_digit = (rx_data >= `CMD_ASCII_0) && (rx_data <= `CMD_ASCII_9);
    assign is_delim = (rx_data == `CMD_ASCII_SPACE) ||
                      (rx_data == `CMD_ASCII_CR) ||
                      (rx_data == `CMD_ASCII_LF);
    assign digit    = rx_data - `CMD_ASCII_0;

    // token leaves on the delimiter byte with no register stage
    assign token.valid = rx_valid && is_delim;
    assign token.value = num_buffer;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_buffer   <= '0;
            num_building <= 1'b0;
        end else if (clear || token.valid) begin
            num_buffer   <= '0;
            num_building <= 1'b0;
        end else if (rx_valid && is_digit) begin
            // wraps mod 256
            num_buffer   <= (num_building ? num_buffer * 8'd10 : '0) + digit;
            num_building <= 1'b1;
        end
        // any other byte is junk and leaves the buffer alone
    end

    // buffer stays zero until a number starts
    a_idle_buffer_zero : assert property (@(posedge clk) disable iff (!rst_n)
        !num_building |-> num_buffer == '0);

endmodule

`default_nettype wire

//--- source/elem_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

module elem_counter (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 clear,
    input  wire logic                 count_en,
    input  wire logic                 load_total,
    input  wire logic [`CMD_DIM_W-1:0] dim_m,
    input  wire logic [`CMD_DIM_W-1:0] dim_n_value,
    output logic                      elem_done
);

    logic [`CMD_CNT_W-1:0]   elem_cnt;
    logic [`CMD_CNT_W-1:0]   elem_total;
    logic [2*`CMD_DIM_W-1:0] product;     // full m*n
    logic                    below_total;

    assign product     = dim_m * dim_n_value;
    assign below_total = elem_cnt < elem_total;
    assign elem_done   = !below_total;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_cnt   <= '0;
            elem_total <= '0;
        end else if (clear) begin  // held in IDLE
            elem_cnt   <= '0;
            elem_total <= '0;
        end else begin
            if (load_total)
                elem_total <= product[`CMD_CNT_W-1:0];  // counter-wide total
            if (count_en && below_total)
                elem_cnt <= elem_cnt + 1'b1;
        end
    end

    // the FSM must stop counting once the total is reached
    a_no_count_past_total : assert property (@(posedge clk) disable iff (!rst_n)
        count_en |-> !elem_done);

endmodule

`default_nettype wire

//--- source/field_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

module field_capture (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  cmd_pkg::token_t             token,
    input  cmd_pkg::load_t              load,
    output logic [`CMD_DIM_W-1:0]       dim_m,
    output logic [`CMD_DIM_W-1:0]       dim_n,
    output logic [`CMD_BYTE_W-1:0]      elem_data,
    output logic [`CMD_ID_W-1:0]        count,
    output logic [`CMD_ID_W-1:0]        user_id_a,
    output logic [`CMD_ID_W-1:0]        user_id_b,
    output logic                        write_en,
    output logic                        user_input_valid,
    output logic                        data_ready
);

    // ========================================
    // field registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dim_m     <= '0;
            dim_n     <= '0;
            elem_data <= '0;
            count     <= '0;
            user_id_a <= '0;
            user_id_b <= '0;
        end else begin
            if (load.dim_m)
                dim_m <= token.value[`CMD_DIM_W-1:0];  // low bits only
            if (load.dim_n)
                dim_n <= token.value[`CMD_DIM_W-1:0];
            if (load.elem)
                elem_data <= token.value;
            if (load.count)
                count <= token.value[`CMD_ID_W-1:0];
            if (load.id_a)
                user_id_a <= token.value[`CMD_ID_W-1:0];
            if (load.id_b)
                user_id_b <= token.value[`CMD_ID_W-1:0];
        end
    end

    // ========================================
    // one-cycle strobes
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_en         <= 1'b0;
            user_input_valid <= 1'b0;
            data_ready       <= 1'b0;
        end else begin
            write_en         <= load.elem;   // same edge as elem_data
            user_input_valid <= load.id_b;   // both ids present by now
            data_ready       <= load.done;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

module uart_cmd_parser (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`CMD_BYTE_W-1:0] rx_data,
    input  wire logic                   rx_valid,
    input  wire logic [1:0]             mode_sel,
    input  wire logic                   start_input,
    input  wire logic                   start_gen,
    input  wire logic                   in_operand_select,
    output logic [`CMD_DIM_W-1:0]       dim_m,
    output logic [`CMD_DIM_W-1:0]       dim_n,
    output logic [`CMD_BYTE_W-1:0]      elem_data,
    output logic [`CMD_ID_W-1:0]        count,
    output logic [`CMD_ID_W-1:0]        user_id_a,
    output logic [`CMD_ID_W-1:0]        user_id_b,
    output logic                        write_en,
    output logic                        user_input_valid,
    output logic                        data_ready
);

    cmd_pkg::token_t token;
    cmd_pkg::load_t  load;
    logic            acc_clear;
    logic            cnt_clear;
    logic            count_en;
    logic            elem_done;

    // ========================================
    // byte stream to numbers
    // ========================================
    decimal_accumulator acc_i (
        .clk(clk), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
        .clear(acc_clear), .token(token)
    );

    cmd_fsm fsm_i (
        .clk(clk), .rst_n(rst_n), .mode_sel(cmd_pkg::mode_t'(mode_sel)),
        .start_input(start_input), .start_gen(start_gen),
        .in_operand_select(in_operand_select), .token(token), .elem_done(elem_done),
        .load(load), .acc_clear(acc_clear), .cnt_clear(cnt_clear), .count_en(count_en)
    );

    // total is m from the register times n straight off the token
    elem_counter cnt_i (
        .clk(clk), .rst_n(rst_n), .clear(cnt_clear), .count_en(count_en),
        .load_total(load.dim_n), .dim_m(dim_m),
        .dim_n_value(token.value[`CMD_DIM_W-1:0]), .elem_done(elem_done)
    );

    field_capture cap_i (
        .clk(clk), .rst_n(rst_n), .token(token), .load(load),
        .dim_m(dim_m), .dim_n(dim_n), .elem_data(elem_data), .count(count),
        .user_id_a(user_id_a), .user_id_b(user_id_b), .write_en(write_en),
        .user_input_valid(user_input_valid), .data_ready(data_ready)
    );

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/cmd_pkg.sv
source/decimal_accumulator.sv
source/elem_counter.sv
source/cmd_fsm.sv
source/field_capture.sv
source/uart_cmd_parser.sv
testbench/tb_uart_cmd_parser.sv

//--- testbench/tb_uart_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_parser;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [1:0]  mode_sel;
    logic        start_input;
    logic        start_gen;
    logic        in_operand_select;
    logic [2:0]  dim_m;
    logic [2:0]  dim_n;
    logic [7:0]  elem_data;
    logic [3:0]  count;
    logic [3:0]  user_id_a;
    logic [3:0]  user_id_b;
    logic        write_en;
    logic        user_input_valid;
    logic        data_ready;

    logic [15:0] lfsr_state;
    logic [7:0]  stream[$];     // bytes of the current command
    logic [7:0]  writes[$];     // elem_data seen with write_en
    int unsigned tokens[$];     // numbers from the reference parse
    int          ready_cnt;
    int          valid_cnt;
    int          checks;
    int          errors;
    int          test_no;
    int          test_err;

    uart_cmd_parser dut_i (.*);

    always #5 clk = ~clk;

    // strobes sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (write_en)
            writes.push_back(elem_data);
        if (data_ready)
            ready_cnt++;
        if (user_input_valid)
            valid_cnt++;
    end

    // ========================================
    // stimulus helpers
    // ========================================
    function automatic int unsigned rand_bits(input int nbits);
        int unsigned r;
        r = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            r = (r << 1) | lfsr_state[0];
        end
        return r;
    endfunction

    // decimal digits, optional letters in between, then one delimiter
    task automatic append_number(input int unsigned value, input bit with_junk);
        logic [7:0]  digits[$];
        int unsigned v;
        v = value;
        do begin
            digits.push_front(8'd48 + 8'(v % 10));
            v = v / 10;
        end while (v != 0);
        foreach (digits[i]) begin
            if (with_junk && rand_bits(2) == 0)
                stream.push_back(8'd97 + 8'(rand_bits(4)));  // 'a'..'p'
            stream.push_back(digits[i]);
        end
        case (rand_bits(2))
            0: stream.push_back(8'd32);
            1: stream.push_back(8'd13);
            default: stream.push_back(8'd10);
        endcase
    endtask

    // reference parse: digits fold in mod 256, letters skipped, delimiter ends a number
    function automatic void parse_stream();
        int unsigned acc;
        acc = 0;
        tokens.delete();
        foreach (stream[i]) begin
            if (stream[i] >= 8'd48 && stream[i] <= 8'd57) begin
                acc = (acc * 10 + stream[i] - 8'd48) % 256;
            end else if (stream[i] == 8'd32 || stream[i] == 8'd13 || stream[i] == 8'd10) begin
                tokens.push_back(acc);
                acc = 0;
            end
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_eq(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic report_test(input string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, test_err);
        test_err = 0;
    endtask

    task automatic begin_cmd(input logic [1:0] mode, input logic sel);
        next_cycle();
        writes.delete();
        ready_cnt = 0;
        valid_cnt = 0;
        mode_sel = mode;
        start_input = (mode == 2'd1);
        start_gen = (mode == 2'd2);
        in_operand_select = sel;
        next_cycle();
        start_input = 1'b0;
        start_gen = 1'b0;
        in_operand_select = 1'b0;
    endtask

    task automatic send_stream();
        int unsigned gap;
        foreach (stream[i]) begin
            gap = rand_bits(2);  // idle cycles before the byte
            repeat (gap) begin
                next_cycle();
                rx_valid = 1'b0;
            end
            next_cycle();
            rx_valid = 1'b1;
            rx_data = stream[i];
        end
        next_cycle();
        rx_valid = 1'b0;
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (ready_cnt == 0 && cycles < 100) begin
            next_cycle();
            cycles++;
        end
        if (ready_cnt == 0) begin
            $display("timeout: %s command never raised data_ready", what);
            $display("Errors found");
            $finish;
        end
        repeat (4) next_cycle();  // room for a stray second pulse
    endtask

    // ========================================
    // command tests
    // ========================================
    task automatic run_input(input bit with_junk);
        int unsigned m;
        int unsigned n;
        int unsigned total;
        m = with_junk ? rand_bits(10) % 1000 : rand_bits(3);
        n = with_junk ? rand_bits(10) % 1000 : rand_bits(3);
        stream.delete();
        append_number(m, with_junk);
        append_number(n, with_junk);
        repeat ((m % 8) * (n % 8))  // m x n as the low dimension bits give it
            append_number(with_junk ? rand_bits(10) % 1000 : rand_bits(8), with_junk);
        begin_cmd(2'd1, 1'b0);
        send_stream();
        wait_ready("matrix input");
        parse_stream();
        // element counter is 5 bits, so the m x n total wraps at 32
        total = ((tokens[0] % 8) * (tokens[1] % 8)) % 32;
        expect_eq(dim_m, tokens[0] % 8, "dim_m");
        expect_eq(dim_n, tokens[1] % 8, "dim_n");
        expect_eq(writes.size(), total, "write_en pulses");
        foreach (writes[i]) begin
            if (i < total)
                expect_eq(writes[i], tokens[2 + i], "elem_data");
        end
        expect_eq(ready_cnt, 1, "data_ready pulses");
        report_test(with_junk ? "junk and multi-digit input" : "matrix input");
    endtask

    task automatic run_gen();
        stream.delete();
        append_number(rand_bits(3), 1'b0);
        append_number(rand_bits(3), 1'b0);
        append_number(rand_bits(8), 1'b0);
        begin_cmd(2'd2, 1'b0);
        send_stream();
        wait_ready("generate");
        parse_stream();
        expect_eq(dim_m, tokens[0] % 8, "dim_m");
        expect_eq(dim_n, tokens[1] % 8, "dim_n");
        expect_eq(count, tokens[2] % 16, "count");
        expect_eq(writes.size(), 0, "write_en pulses");
        expect_eq(ready_cnt, 1, "data_ready pulses");
        report_test("generate");
    endtask

    task automatic run_select();
        stream.delete();
        append_number(rand_bits(8), 1'b0);
        append_number(rand_bits(8), 1'b0);
        begin_cmd(2'd1, 1'b1);  // start_input rises too and must lose
        send_stream();
        wait_ready("operand select");
        parse_stream();
        expect_eq(user_id_a, tokens[0] % 16, "user_id_a");
        expect_eq(user_id_b, tokens[1] % 16, "user_id_b");
        expect_eq(valid_cnt, 1, "user_input_valid pulses");
        expect_eq(writes.size(), 0, "write_en pulses");
        expect_eq(ready_cnt, 1, "data_ready pulses");
        report_test("operand select");
    endtask

    initial begin
        lfsr_state = 16'd51983;
        rst_n = 1'b0;
        rx_data = 8'd0;
        rx_valid = 1'b0;
        mode_sel = 2'd0;
        start_input = 1'b0;
        start_gen = 1'b0;
        in_operand_select = 1'b0;
        ready_cnt = 0;
        valid_cnt = 0;
        checks = 0;
        errors = 0;
        test_no = 0;
        test_err = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        expect_eq({dim_m, dim_n, elem_data, count, user_id_a, user_id_b}, 0, "fields after reset");
        expect_eq({write_en, user_input_valid, data_ready}, 0, "strobes after reset");
        stream.delete();
        repeat (6) append_number(rand_bits(8), 1'b1);  // no start, all dropped
        send_stream();
        repeat (4) next_cycle();
        expect_eq(writes.size() + ready_cnt + valid_cnt, 0, "strobes from idle bytes");
        expect_eq({dim_m, dim_n, elem_data, count, user_id_a, user_id_b}, 0, "fields after idle");
        report_test("reset and idle bytes");

        repeat (4) run_input(1'b0);
        repeat (3) run_gen();
        repeat (3) run_select();
        repeat (3) run_input(1'b1);

        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
